// ==== hdl/lot_pkg.sv ====
`default_nettype none

package lot_pkg;

    localparam int MAX_FLOORS = 7; // highest floor a 3-bit floor number reaches

    typedef logic [15:0] plate_t;  // 0 means no car
    typedef logic [7:0]  fee_t;    // saturates at 255
    typedef logic [3:0]  count_t;  // free spots of one class

    // top nibble of the plate
    localparam logic [3:0] CLASS_HANDICAPPED = 4'd9;
    localparam logic [3:0] CLASS_HYBRID      = 4'd8;

    typedef struct packed {
        logic [2:0] floor;
        logic       side;   // 0 left, 1 right
    } spot_t;

    // one write into the spot table, plate 0 vacates the spot
    typedef struct packed {
        logic   we;
        spot_t  spot;
        plate_t plate;
    } park_t;

    typedef struct packed {
        plate_t [MAX_FLOORS:1] left;
        plate_t [MAX_FLOORS:1] right;
    } lot_view_t;

    function automatic logic is_suv(plate_t plate);
        return plate[0]; // odd plate
    endfunction

    function automatic logic is_handicapped(plate_t plate);
        return plate[15:12] == CLASS_HANDICAPPED;
    endfunction

    function automatic plate_t plate_at(lot_view_t view, logic [2:0] floor, logic side);
        return side ? view.right[floor] : view.left[floor];
    endfunction

endpackage

`default_nettype wire

// ==== hdl/lift_pkg.sv ====
`default_nettype none

package lift_pkg;

    typedef logic [2:0] floor_t; // 0 is the ground floor

    typedef enum logic {
        ORDER_IN,
        ORDER_OUT
    } order_kind_t;

    typedef struct packed {
        order_kind_t     kind;
        lot_pkg::plate_t plate;
    } order_t;

    // one full trip always starts and ends at floor 0
    typedef enum logic [2:0] {
        LIFT_IDLE,
        LIFT_LOAD,  // car onto the platform, first floor of the climb
        LIFT_UP,
        LIFT_DROP,  // park or fetch at the destination
        LIFT_DOWN,
        LIFT_DONE
    } lift_state_t;

endpackage

`default_nettype wire

// ==== hdl/order_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module order_queue #(
    parameter int QUEUE_DEPTH = 7
) (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            in_mode,
    input  wire logic            out_mode,
    input  wire lot_pkg::plate_t plate,
    input  wire logic            lift_ready,
    output lift_pkg::order_t     order,
    output logic                 order_valid,
    output logic                 queue_full
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    lift_pkg::order_t slots [QUEUE_DEPTH];
    lift_pkg::order_t incoming;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        incoming.kind  = out_mode ? lift_pkg::ORDER_OUT : lift_pkg::ORDER_IN;
        incoming.plate = plate;
    end

    assign queue_full = (count == CNT_W'(QUEUE_DEPTH));
    assign push       = (in_mode ^ out_mode) && !queue_full; // both modes at once is no order
    // the lift only leaves idle one cycle after order_valid, so hold off then
    assign pop        = lift_ready && !order_valid && (count != '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            order_valid <= 1'b0;
        end else begin
            order_valid <= pop;
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            slots[tail] <= incoming;
        end
        if (pop) begin
            order <= slots[head]; // shown to the lift with order_valid
        end
    end

endmodule

`default_nettype wire

// ==== hdl/slot_allocator.sv ====
`timescale 1ns/100ps
`default_nettype none

module slot_allocator #(
    parameter int NUM_FLOORS = 7
) (
    input  wire lift_pkg::order_t    order,
    input  wire lot_pkg::lot_view_t  lot_view,
    input  wire lot_pkg::count_t     empty_sedan,
    output lot_pkg::spot_t           dest,
    output logic                     dest_ok
);

    logic            suv;
    logic            handicapped;
    logic            sedan_spill;  // sedans may go to odd floors
    logic            floor_fits;
    logic            reserved;
    logic            hit;
    lot_pkg::plate_t here;

    always_comb begin
        suv         = lot_pkg::is_suv(order.plate);
        handicapped = lot_pkg::is_handicapped(order.plate);
        sedan_spill = (empty_sedan == '0);
        floor_fits  = 1'b0;
        reserved    = 1'b0;
        hit         = 1'b0;
        here        = '0;
        dest        = '0;
        dest_ok     = 1'b0;

        // lowest floor first, left before right
        for (int f = 1; f <= NUM_FLOORS; f++) begin
            for (int s = 0; s < 2; s++) begin
                here = lot_pkg::plate_at(lot_view, 3'(f), s[0]);
                if (order.kind == lift_pkg::ORDER_OUT) begin
                    hit = (order.plate != '0) && (here == order.plate);
                end else begin
                    floor_fits = f[0] ? (suv || sedan_spill) : !suv; // odd floors are SUV
                    reserved   = (s == 0) && (f <= 2) && !handicapped;
                    hit        = floor_fits && !reserved && (here == '0);
                end
                if (hit && !dest_ok) begin
                    dest.floor = 3'(f);
                    dest.side  = s[0];
                    dest_ok    = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lift_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module lift_controller #(
    parameter int NUM_FLOORS = 7
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire lift_pkg::order_t order,
    input  wire logic             order_valid,
    input  wire lot_pkg::spot_t   dest,
    input  wire logic             dest_ok,
    output logic                  lift_ready,
    output lift_pkg::floor_t      current_floor,
    output lot_pkg::plate_t       moving,
    output lot_pkg::park_t        park,
    output logic                  car_out,
    output logic                  order_done
);

    localparam lift_pkg::floor_t TOP_FLOOR = lift_pkg::floor_t'(NUM_FLOORS);

    lift_pkg::lift_state_t state;
    lift_pkg::order_t      order_q;
    lot_pkg::spot_t        dest_q;
    logic                  ok_q;
    lift_pkg::floor_t      next_up;
    logic                  at_stop;
    logic                  entering;

    assign next_up  = current_floor + 1'b1;
    // top floor check only guards against a destination out of range
    assign at_stop  = (next_up == dest_q.floor) || (next_up == TOP_FLOOR);
    assign entering = (order_q.kind == lift_pkg::ORDER_IN);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= lift_pkg::LIFT_IDLE;
            current_floor <= '0;
            moving        <= '0;
        end else begin
            case (state)
                lift_pkg::LIFT_IDLE: begin
                    if (order_valid) begin
                        state <= dest_ok ? lift_pkg::LIFT_LOAD : lift_pkg::LIFT_DONE;
                    end
                end
                lift_pkg::LIFT_LOAD: begin
                    current_floor <= next_up;
                    if (entering) begin
                        moving <= order_q.plate;
                    end
                    state <= at_stop ? lift_pkg::LIFT_DROP : lift_pkg::LIFT_UP;
                end
                lift_pkg::LIFT_UP: begin
                    current_floor <= next_up;
                    if (at_stop) begin
                        state <= lift_pkg::LIFT_DROP;
                    end
                end
                lift_pkg::LIFT_DROP: begin
                    moving <= entering ? '0 : order_q.plate; // car parked or fetched
                    state  <= lift_pkg::LIFT_DOWN;
                end
                lift_pkg::LIFT_DOWN: begin
                    current_floor <= current_floor - 1'b1;
                    if (current_floor == lift_pkg::floor_t'(1)) begin
                        state <= lift_pkg::LIFT_DONE;
                    end
                end
                lift_pkg::LIFT_DONE: begin
                    moving <= '0; // car leaves at the ground floor
                    state  <= lift_pkg::LIFT_IDLE;
                end
                default: state <= lift_pkg::LIFT_IDLE;
            endcase
        end
    end

    // order and spot held for the whole trip
    always_ff @(posedge clock) begin
        if ((state == lift_pkg::LIFT_IDLE) && order_valid) begin
            order_q <= order;
            dest_q  <= dest;
            ok_q    <= dest_ok;
        end
    end

    assign lift_ready = (state == lift_pkg::LIFT_IDLE);
    assign order_done = (state == lift_pkg::LIFT_DONE);
    assign car_out    = order_done && ok_q && !entering;

    always_comb begin
        park.we    = (state == lift_pkg::LIFT_DROP);
        park.spot  = dest_q;
        park.plate = entering ? order_q.plate : '0;
    end

endmodule

`default_nettype wire

// ==== hdl/spot_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module spot_table #(
    parameter int NUM_FLOORS = 7
) (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire lot_pkg::park_t park,
    output lot_pkg::lot_view_t  lot_view,
    output lot_pkg::fee_t       fee,
    output lot_pkg::plate_t     out_plate,
    output lot_pkg::count_t     empty_suv,
    output lot_pkg::count_t     empty_sedan,
    output logic                full_suv,
    output logic                full_sedan
);

    lot_pkg::fee_t   park_time [1:NUM_FLOORS][2]; // cycles parked, saturating
    lot_pkg::plate_t leaving;

    function automatic lot_pkg::fee_t fee_for(lot_pkg::plate_t plate, lot_pkg::fee_t ticks);
        logic [8:0] twice;
        twice = {ticks, 1'b0};
        if (lot_pkg::is_handicapped(plate)) begin
            return '0;
        end
        if (plate[15:12] == lot_pkg::CLASS_HYBRID) begin
            return ticks;
        end
        return twice[8] ? '1 : twice[7:0];
    endfunction

    assign leaving = lot_pkg::plate_at(lot_view, park.spot.floor, park.spot.side);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lot_view <= '0;
        end else if (park.we) begin
            if (park.spot.side) begin
                lot_view.right[park.spot.floor] <= park.plate;
            end else begin
                lot_view.left[park.spot.floor] <= park.plate;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int f = 1; f <= NUM_FLOORS; f++) begin
            for (int s = 0; s < 2; s++) begin
                if ((lot_pkg::plate_at(lot_view, 3'(f), s[0]) != '0) &&
                    (park_time[f][s] != '1)) begin
                    park_time[f][s] <= park_time[f][s] + 1'b1;
                end
            end
        end
        if (park.we) begin
            if (park.plate != '0) begin
                park_time[park.spot.floor][park.spot.side] <= '0; // new car, restart
            end else begin
                out_plate <= leaving;
                fee       <= fee_for(leaving, park_time[park.spot.floor][park.spot.side]);
            end
        end
    end

    // odd floors count as SUV spots, even floors as sedan spots
    always_comb begin
        empty_suv   = '0;
        empty_sedan = '0;
        for (int f = 1; f <= NUM_FLOORS; f++) begin
            for (int s = 0; s < 2; s++) begin
                if (lot_pkg::plate_at(lot_view, 3'(f), s[0]) == '0) begin
                    if (f[0]) begin
                        empty_suv = empty_suv + 1'b1;
                    end else begin
                        empty_sedan = empty_sedan + 1'b1;
                    end
                end
            end
        end
    end

    assign full_suv   = (empty_suv == '0);
    assign full_sedan = (empty_sedan == '0);

endmodule

`default_nettype wire

// ==== hdl/parking_tower.sv ====
`timescale 1ns/100ps
`default_nettype none

module parking_tower #(
    parameter int NUM_FLOORS  = 7,
    parameter int QUEUE_DEPTH = 7
) (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            in_mode,
    input  wire logic            out_mode,
    input  wire lot_pkg::plate_t plate,
    output lift_pkg::floor_t     current_floor,
    output lot_pkg::plate_t      moving,   // car on the platform
    output logic                 car_out,
    output lot_pkg::plate_t      out_plate,
    output lot_pkg::fee_t        fee,
    output logic                 order_done,
    output logic                 queue_full,
    output lot_pkg::count_t      empty_suv,
    output lot_pkg::count_t      empty_sedan,
    output logic                 full_suv,
    output logic                 full_sedan
);

    lift_pkg::order_t   order;
    logic               order_valid;
    logic               lift_ready;
    lot_pkg::spot_t     dest;
    logic               dest_ok;
    lot_pkg::park_t     park;
    lot_pkg::lot_view_t lot_view;

    order_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_i (
        .clock, .reset, .in_mode, .out_mode, .plate, .lift_ready,
        .order, .order_valid, .queue_full
    );

    slot_allocator #(.NUM_FLOORS(NUM_FLOORS)) alloc_i (
        .order, .lot_view, .empty_sedan, .dest, .dest_ok
    );

    lift_controller #(.NUM_FLOORS(NUM_FLOORS)) lift_i (
        .clock, .reset, .order, .order_valid, .dest, .dest_ok,
        .lift_ready, .current_floor, .moving, .park, .car_out, .order_done
    );

    spot_table #(.NUM_FLOORS(NUM_FLOORS)) spots_i (
        .clock, .reset, .park, .lot_view, .fee, .out_plate,
        .empty_suv, .empty_sedan, .full_suv, .full_sedan
    );

endmodule

`default_nettype wire

// ==== bench/parking_tower_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module parking_tower_assert (
    input wire logic             clock,
    input wire logic             reset,
    input wire logic             lift_ready,
    input wire lift_pkg::floor_t current_floor,
    input wire lot_pkg::spot_t   trip_dest,
    input wire logic             order_done
);

    logic [3:0] floor_wide; // extra bit so a step from 7 does not wrap

    assign floor_wide = {1'b0, current_floor};

    // every order ends with the lift back at the ground floor
    done_at_ground: assert property (
        @(posedge clock) disable iff (reset) order_done |-> (current_floor == '0)
    ) else $error("order finished with the lift at floor %0d", current_floor);

    floor_within_trip: assert property (
        @(posedge clock) disable iff (reset)
            !lift_ready |-> (current_floor <= trip_dest.floor)
    ) else $error("lift above its destination floor at %0d", current_floor);

    floor_single_step: assert property (
        @(posedge clock) disable iff (reset)
            (floor_wide == $past(floor_wide)) ||
            (floor_wide == $past(floor_wide) + 4'd1) ||
            (floor_wide + 4'd1 == $past(floor_wide))
    ) else $error("lift moved more than one floor in a cycle");

endmodule

bind lift_controller parking_tower_assert assert_i (
    .clock, .reset, .lift_ready, .current_floor, .trip_dest(dest_q), .order_done
);

`default_nettype wire

// ==== bench/parking_tower_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module parking_tower_tb;

    localparam int NUM_FLOORS  = 7;
    localparam int QUEUE_DEPTH = 7;
    localparam int SUV_SPOTS   = 2 * ((NUM_FLOORS + 1) / 2); // odd floors
    localparam int SEDAN_SPOTS = 2 * (NUM_FLOORS / 2);
    localparam int NUM_ORDERS  = 15;
    localparam int BURST       = QUEUE_DEPTH + 2;
    localparam int TIMEOUT     = NUM_ORDERS * 20 + 100;

    typedef enum logic [1:0] {
        FEE_NONE,   // entry, nothing to bill
        FEE_ZERO,   // handicapped
        FEE_TIME,   // hybrid
        FEE_DOUBLE  // standard car, twice the time
    } fee_rule_t;

    typedef struct packed {
        lift_pkg::order_kind_t kind;
        lot_pkg::plate_t       plate;
        lot_pkg::count_t       suv;       // free spots once the order is done
        lot_pkg::count_t       sedan;
        lot_pkg::plate_t       out_plate; // 0 when no car comes out
        fee_rule_t             rule;
    } order_row_t;

    logic               clock;
    logic               reset;
    logic               in_mode;
    logic               out_mode;
    lot_pkg::plate_t    plate;
    lift_pkg::floor_t   current_floor;
    lot_pkg::plate_t    moving;
    logic               car_out;
    lot_pkg::plate_t    out_plate;
    lot_pkg::fee_t      fee;
    logic               order_done;
    logic               queue_full;
    lot_pkg::count_t    empty_suv;
    lot_pkg::count_t    empty_sedan;
    logic               full_suv;
    logic               full_sedan;

    order_row_t rows [NUM_ORDERS];
    int         errors    = 0;
    int         checks    = 0;
    int         cycles    = 0;
    int         done_seen = 0;
    int         out_seen  = 0;
    integer     seed;

    parking_tower #(.NUM_FLOORS(NUM_FLOORS), .QUEUE_DEPTH(QUEUE_DEPTH)) dut_i (
        .clock, .reset, .in_mode, .out_mode, .plate, .current_floor, .moving,
        .car_out, .out_plate, .fee, .order_done, .queue_full,
        .empty_suv, .empty_sedan, .full_suv, .full_sedan
    );

    always #10 clock = ~clock;

    always @(negedge clock) begin
        if (order_done) begin
            done_seen++;
        end
        if (car_out) begin
            out_seen++;
        end
    end

    task automatic check_value(string name, logic [15:0] expected, logic [15:0] actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_fee(string name, fee_rule_t rule);
        logic ok;
        case (rule)
            FEE_ZERO:   ok = (fee == 8'd0);
            FEE_TIME:   ok = (fee != 8'd0);
            FEE_DOUBLE: ok = (fee != 8'd0) && (!fee[0] || (fee == 8'hff)); // 255 is saturated
            default:    ok = 1'b1;
        endcase
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR %s: expected fee rule %s, actual fee %0d", name, rule.name(), fee);
        end
    endtask

    task automatic push_order(lift_pkg::order_kind_t kind, lot_pkg::plate_t value);
        @(posedge clock);
        #1;
        in_mode  = (kind == lift_pkg::ORDER_IN);
        out_mode = (kind == lift_pkg::ORDER_OUT);
        plate    = value;
        @(posedge clock);
        #1;
        in_mode  = 1'b0;
        out_mode = 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clock);
        while (!order_done) begin
            @(negedge clock);
        end
    endtask

    task automatic run_row(int i);
        order_row_t row;
        string      name;
        row  = rows[i];
        name = $sformatf("order %0d plate %h", i, row.plate);
        push_order(row.kind, row.plate);
        wait_done();
        check_value({name, " car_out"}, 16'(row.out_plate != '0), 16'(car_out));
        check_value({name, " moving"}, row.out_plate, moving); // fetched car still on board
        if (row.out_plate != '0) begin
            check_value({name, " out_plate"}, row.out_plate, out_plate);
            check_fee(name, row.rule);
        end
        check_value({name, " empty_suv"}, 16'(row.suv), 16'(empty_suv));
        check_value({name, " empty_sedan"}, 16'(row.sedan), 16'(empty_sedan));
        check_value({name, " full_suv"}, 16'(row.suv == '0), 16'(full_suv));
        check_value({name, " full_sedan"}, 16'(row.sedan == '0), 16'(full_sedan));
    endtask

    // long trip to floor 6, then more orders than the queue holds
    task automatic overflow_burst();
        logic [31:0] r;
        int          done_start;
        int          out_start;
        push_order(lift_pkg::ORDER_OUT, 16'h222a); // parked on floor 6 right
        done_start = done_seen;
        out_start  = out_seen;
        while (current_floor == '0) begin
            @(negedge clock);
        end
        for (int b = 0; b < BURST; b++) begin
            @(posedge clock);
            #1;
            r        = $random(seed);
            out_mode = 1'b1;
            plate    = {4'hf, r[11:0]}; // no parked plate has a top nibble of f
        end
        @(posedge clock);
        #1;
        out_mode = 1'b0;
        @(negedge clock);
        check_value("burst queue_full", 16'd1, 16'(queue_full));
        while ((done_seen - done_start) < (QUEUE_DEPTH + 1)) begin
            @(negedge clock);
        end
        repeat (10) @(negedge clock);
        check_value("burst orders done", 16'(QUEUE_DEPTH + 1), 16'(done_seen - done_start));
        check_value("burst cars out", 16'd1, 16'(out_seen - out_start));
    endtask

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        seed     = 32'h0080_d231;
        clock    = 1'b0;
        reset    = 1'b1;
        in_mode  = 1'b0;
        out_mode = 1'b0;
        plate    = '0;

        rows[0]  = '{lift_pkg::ORDER_IN,  16'h1230, 4'd8, 4'd5, 16'h0000, FEE_NONE};   // 2R
        rows[1]  = '{lift_pkg::ORDER_IN,  16'h1231, 4'd7, 4'd5, 16'h0000, FEE_NONE};   // 1R
        rows[2]  = '{lift_pkg::ORDER_IN,  16'h9002, 4'd7, 4'd4, 16'h0000, FEE_NONE};   // 2L
        rows[3]  = '{lift_pkg::ORDER_IN,  16'h8005, 4'd6, 4'd4, 16'h0000, FEE_NONE};   // 3L
        rows[4]  = '{lift_pkg::ORDER_IN,  16'h2224, 4'd6, 4'd3, 16'h0000, FEE_NONE};
        rows[5]  = '{lift_pkg::ORDER_IN,  16'h2226, 4'd6, 4'd2, 16'h0000, FEE_NONE};
        rows[6]  = '{lift_pkg::ORDER_IN,  16'h2228, 4'd6, 4'd1, 16'h0000, FEE_NONE};
        rows[7]  = '{lift_pkg::ORDER_IN,  16'h222a, 4'd6, 4'd0, 16'h0000, FEE_NONE};   // 6R
        rows[8]  = '{lift_pkg::ORDER_IN,  16'h333c, 4'd5, 4'd0, 16'h0000, FEE_NONE};   // spill, 3R
        rows[9]  = '{lift_pkg::ORDER_OUT, 16'h9002, 4'd5, 4'd1, 16'h9002, FEE_ZERO};
        rows[10] = '{lift_pkg::ORDER_OUT, 16'h8005, 4'd6, 4'd1, 16'h8005, FEE_TIME};
        rows[11] = '{lift_pkg::ORDER_OUT, 16'h1230, 4'd6, 4'd2, 16'h1230, FEE_DOUBLE};
        rows[12] = '{lift_pkg::ORDER_OUT, 16'h7777, 4'd6, 4'd2, 16'h0000, FEE_NONE};   // unknown
        rows[13] = '{lift_pkg::ORDER_IN,  16'h9011, 4'd5, 4'd2, 16'h0000, FEE_NONE};   // 1L
        rows[14] = '{lift_pkg::ORDER_OUT, 16'h333c, 4'd6, 4'd2, 16'h333c, FEE_DOUBLE};

        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        check_value("reset empty_suv", 16'(SUV_SPOTS), 16'(empty_suv));
        check_value("reset empty_sedan", 16'(SEDAN_SPOTS), 16'(empty_sedan));
        check_value("reset flags", 16'd0,
                    16'({full_suv, full_sedan, queue_full, car_out, order_done}));
        check_value("reset current_floor", 16'd0, 16'(current_floor));

        for (int i = 0; i < NUM_ORDERS; i++) begin
            run_row(i);
        end
        overflow_burst();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== parking_tower.f ====
hdl/lot_pkg.sv
hdl/lift_pkg.sv
hdl/order_queue.sv
hdl/slot_allocator.sv
hdl/lift_controller.sv
hdl/spot_table.sv
hdl/parking_tower.sv
bench/parking_tower_assert.sv
bench/parking_tower_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := parking_tower_tb
FILELIST  := parking_tower.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := CHECKS FAILED
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
